/* src/soc_pkg.sv */
package soc_pkg;

  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] data_t;
  typedef logic [15:0] led_t;

  // bit 0 uart, bit 1 spi
  typedef logic [1:0]  irq_t;

  typedef enum logic [1:0] {
    dmi_op_nop   = 2'd0,
    dmi_op_read  = 2'd1,
    dmi_op_write = 2'd2
  } dmi_op_t;

  typedef enum logic [1:0] {
    dmi_resp_ok     = 2'd0,
    dmi_resp_failed = 2'd2
  } dmi_resp_t;

  typedef enum logic [1:0] {
    state_idle,
    state_bus,
    state_respond
  } dm_state_t;

  // dmcontrol holds ndmreset in bit 1 and dmactive in bit 0
  localparam dmi_addr_t DMCONTROL_ADDR = 7'h10;
  localparam int        NDMRESET_BIT   = 1;

  localparam dmi_addr_t MMIO_BASE  = 7'h20;
  localparam int        MMIO_WORDS = 4;
  localparam dmi_addr_t MEM_BASE   = 7'h40;

  // word offsets inside the mmio region
  localparam logic [1:0] MMIO_LED     = 2'd0;
  localparam logic [1:0] MMIO_PENDING = 2'd1;
  localparam logic [1:0] MMIO_ENABLE  = 2'd2;
  localparam logic [1:0] MMIO_STATUS  = 2'd3;

endpackage

/* src/sys_bus_if.sv */
`timescale 1ns/1ps

interface sys_bus_if import soc_pkg::*; ();

  logic      req_valid;
  logic      req_write;
  dmi_addr_t req_addr;
  data_t     req_wdata;
  logic      req_ready;

  // one resp_valid pulse per accepted request
  logic      resp_valid;
  data_t     resp_rdata;
  logic      resp_err;

  modport master (
    output req_valid, req_write, req_addr, req_wdata,
    input  req_ready,
    input  resp_valid, resp_rdata, resp_err
  );

  modport slave (
    input  req_valid, req_write, req_addr, req_wdata,
    output req_ready,
    output resp_valid, resp_rdata, resp_err
  );

endinterface

/* src/debug_module.sv */
`timescale 1ns/1ps

module debug_module import soc_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      dmi_req_valid,
  output logic      dmi_req_ready,
  input  dmi_addr_t dmi_req_addr,
  input  data_t     dmi_req_data,
  input  dmi_op_t   dmi_req_op,
  output logic      dmi_resp_valid,
  input  logic      dmi_resp_ready,
  output data_t     dmi_resp_data,
  output dmi_resp_t dmi_resp_resp,
  output logic      sys_reset,
  sys_bus_if.master bus
);

  dm_state_t  state;
  logic [1:0] dmcontrol;
  logic       req_sent;

  // latched request and response
  logic       bus_write;
  dmi_addr_t  bus_addr;
  data_t      bus_wdata;
  data_t      resp_data;
  dmi_resp_t  resp_code;

  logic req_fire;
  logic is_access;
  logic ctl_hit;
  logic local_req;

  assign req_fire  = dmi_req_valid && dmi_req_ready;
  assign is_access = (dmi_req_op == dmi_op_read) || (dmi_req_op == dmi_op_write);
  assign ctl_hit   = is_access && (dmi_req_addr == DMCONTROL_ADDR);
  // nop, reserved op and dmcontrol never reach the bus
  assign local_req = !is_access || ctl_hit;

  assign dmi_req_ready  = (state == state_idle);
  assign dmi_resp_valid = (state == state_respond);
  assign dmi_resp_data  = resp_data;
  assign dmi_resp_resp  = resp_code;

  assign bus.req_valid = (state == state_bus) && !req_sent;
  assign bus.req_write = bus_write;
  assign bus.req_addr  = bus_addr;
  assign bus.req_wdata = bus_wdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= state_idle;
      dmcontrol <= 2'b00;
      req_sent  <= 1'b0;
    end else begin
      case (state)
        state_idle: begin
          if (req_fire) begin
            if (ctl_hit && dmi_req_op == dmi_op_write) begin
              dmcontrol <= dmi_req_data[1:0];
            end
            // system held in reset, bus access fails at once
            if (local_req || sys_reset) begin
              state <= state_respond;
            end else begin
              state <= state_bus;
            end
          end
        end
        state_bus: begin
          if (bus.req_valid && bus.req_ready) begin
            req_sent <= 1'b1;
          end
          if (req_sent && bus.resp_valid) begin
            req_sent <= 1'b0;
            state    <= state_respond;
          end
        end
        state_respond: begin
          if (dmi_resp_ready) begin
            state <= state_idle;
          end
        end
        default: state <= state_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_fire) begin
      bus_addr  <= dmi_req_addr;
      bus_wdata <= dmi_req_data;
      bus_write <= (dmi_req_op == dmi_op_write);
      resp_data <= '0;
      resp_code <= dmi_resp_ok;
      if (ctl_hit && dmi_req_op == dmi_op_read) begin
        resp_data <= data_t'(dmcontrol);
      end
      if (!local_req && sys_reset) begin
        resp_code <= dmi_resp_failed;
      end
    end else if (state == state_bus && req_sent && bus.resp_valid) begin
      resp_data <= bus_write ? '0 : bus.resp_rdata;
      resp_code <= bus.resp_err ? dmi_resp_failed : dmi_resp_ok;
    end
  end

  // registered so the system leaves reset one cycle after ndmreset clears
  always_ff @(posedge clock) begin
    sys_reset <= reset || dmcontrol[NDMRESET_BIT];
  end

endmodule

/* src/bus_router.sv */
`timescale 1ns/1ps

module bus_router import soc_pkg::*; #(
  parameter int MEM_WORDS = 64
) (
  input  logic      clock,
  input  logic      reset,
  sys_bus_if.slave  up,
  sys_bus_if.master mem,
  sys_bus_if.master mmio
);

  logic sel_mem;
  logic sel_mmio;
  logic accept;

  // outstanding target
  logic pend_mem;
  logic pend_mmio;
  logic pend_err;

  assign sel_mmio = (up.req_addr >= MMIO_BASE) &&
                    (int'(up.req_addr) < int'(MMIO_BASE) + MMIO_WORDS);
  assign sel_mem  = (up.req_addr >= MEM_BASE) &&
                    (int'(up.req_addr) < int'(MEM_BASE) + MEM_WORDS);

  assign mem.req_valid  = up.req_valid && sel_mem;
  assign mem.req_write  = up.req_write;
  assign mem.req_addr   = up.req_addr;
  assign mem.req_wdata  = up.req_wdata;

  assign mmio.req_valid = up.req_valid && sel_mmio;
  assign mmio.req_write = up.req_write;
  assign mmio.req_addr  = up.req_addr;
  assign mmio.req_wdata = up.req_wdata;

  // unmapped addresses are taken at once
  assign up.req_ready = sel_mem ? mem.req_ready : (sel_mmio ? mmio.req_ready : 1'b1);
  assign accept = up.req_valid && up.req_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      pend_mem  <= 1'b0;
      pend_mmio <= 1'b0;
      pend_err  <= 1'b0;
    end else if (accept) begin
      pend_mem  <= sel_mem;
      pend_mmio <= sel_mmio;
      pend_err  <= !sel_mem && !sel_mmio;
    end else begin
      if (mem.resp_valid) begin
        pend_mem <= 1'b0;
      end
      if (mmio.resp_valid) begin
        pend_mmio <= 1'b0;
      end
      pend_err <= 1'b0;
    end
  end

  assign up.resp_valid = (pend_mem && mem.resp_valid) || (pend_mmio && mmio.resp_valid) ||
                         pend_err;
  assign up.resp_rdata = pend_mmio ? mmio.resp_rdata : (pend_mem ? mem.resp_rdata : '0);
  assign up.resp_err   = pend_err || (pend_mem && mem.resp_err) ||
                         (pend_mmio && mmio.resp_err);

endmodule

/* src/scratch_mem.sv */
`timescale 1ns/1ps

module scratch_mem import soc_pkg::*; #(
  parameter int MEM_WORDS = 64
) (
  input  logic     clock,
  sys_bus_if.slave bus
);

  localparam int AW = $clog2(MEM_WORDS);

  data_t          ram [MEM_WORDS];
  logic [AW-1:0]  index;
  data_t          rdata;
  logic           resp_valid;

  // word index from the low address bits
  assign index = bus.req_addr[AW-1:0];

  assign bus.req_ready  = 1'b1;
  assign bus.resp_valid = resp_valid;
  assign bus.resp_rdata = rdata;
  assign bus.resp_err   = 1'b0;

  always_ff @(posedge clock) begin
    if (bus.req_valid) begin
      if (bus.req_write) begin
        ram[index] <= bus.req_wdata;
      end
      rdata <= ram[index];
    end
  end

  // response one cycle after each request
  always_ff @(posedge clock) begin
    resp_valid <= bus.req_valid;
  end

endmodule

/* src/mmio_regs.sv */
`timescale 1ns/1ps

module mmio_regs import soc_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  irq_t     ext_irq,
  sys_bus_if.slave bus,
  output led_t     led,
  output irq_t     irq
);

  data_t      led_reg;
  irq_t       pending;
  irq_t       enable;
  irq_t       status;
  irq_t       clear;
  data_t      rdata;
  logic       resp_valid;
  logic [1:0] offset;
  logic       wr_en;

  assign offset = bus.req_addr[1:0];
  assign wr_en  = bus.req_valid && bus.req_write;

  // write 1 to clear pending bits
  assign clear  = (wr_en && offset == MMIO_PENDING) ? bus.req_wdata[1:0] : '0;
  assign status = pending & enable;

  assign led = led_reg[15:0];
  assign irq = status;

  assign bus.req_ready  = 1'b1;
  assign bus.resp_valid = resp_valid;
  assign bus.resp_rdata = rdata;
  assign bus.resp_err   = 1'b0;

  always_ff @(posedge clock) begin
    if (reset) begin
      led_reg    <= '0;
      pending    <= '0;
      enable     <= '0;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= bus.req_valid;
      // a high line wins over a clear in the same cycle
      pending    <= (pending & ~clear) | ext_irq;
      if (wr_en && offset == MMIO_LED) begin
        led_reg <= bus.req_wdata;
      end
      if (wr_en && offset == MMIO_ENABLE) begin
        enable <= bus.req_wdata[1:0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bus.req_valid) begin
      case (offset)
        MMIO_LED:     rdata <= led_reg;
        MMIO_PENDING: rdata <= data_t'(pending);
        MMIO_ENABLE:  rdata <= data_t'(enable);
        MMIO_STATUS:  rdata <= data_t'(status);
        default:      rdata <= '0;
      endcase
    end
  end

endmodule

/* src/soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
  parameter int MEM_WORDS = 64
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      dmi_req_valid,
  output logic      dmi_req_ready,
  input  dmi_addr_t dmi_req_addr,
  input  data_t     dmi_req_data,
  input  dmi_op_t   dmi_req_op,
  output logic      dmi_resp_valid,
  input  logic      dmi_resp_ready,
  output data_t     dmi_resp_data,
  output dmi_resp_t dmi_resp_resp,
  input  irq_t      ext_irq,
  output led_t      led,
  output irq_t      irq
);

  // reset | ndmreset, registered in the debug module
  logic sys_reset;

  sys_bus_if dm_bus ();
  sys_bus_if mem_bus ();
  sys_bus_if mmio_bus ();

  debug_module dm (
    .clock          (clock),
    .reset          (reset),
    .dmi_req_valid  (dmi_req_valid),
    .dmi_req_ready  (dmi_req_ready),
    .dmi_req_addr   (dmi_req_addr),
    .dmi_req_data   (dmi_req_data),
    .dmi_req_op     (dmi_req_op),
    .dmi_resp_valid (dmi_resp_valid),
    .dmi_resp_ready (dmi_resp_ready),
    .dmi_resp_data  (dmi_resp_data),
    .dmi_resp_resp  (dmi_resp_resp),
    .sys_reset      (sys_reset),
    .bus            (dm_bus)
  );

  bus_router #(.MEM_WORDS(MEM_WORDS)) router (
    .clock (clock),
    .reset (sys_reset),
    .up    (dm_bus),
    .mem   (mem_bus),
    .mmio  (mmio_bus)
  );

  scratch_mem #(.MEM_WORDS(MEM_WORDS)) mem (
    .clock (clock),
    .bus   (mem_bus)
  );

  mmio_regs mmio (
    .clock   (clock),
    .reset   (sys_reset),
    .ext_irq (ext_irq),
    .bus     (mmio_bus),
    .led     (led),
    .irq     (irq)
  );

endmodule

/* testbench/soc_asserts.sv */
`timescale 1ns/1ps

module soc_asserts import soc_pkg::*; (
  input logic      clock,
  input logic      reset,
  input logic      dmi_req_valid,
  input logic      dmi_req_ready,
  input logic      dmi_resp_valid,
  input logic      dmi_resp_ready,
  input data_t     dmi_resp_data,
  input dmi_resp_t dmi_resp_resp,
  input logic      bus_req_valid,
  input logic      bus_req_ready,
  input logic      bus_resp_valid
);

  int fail_count = 0;

  // one bus request in flight
  logic outstanding;

  // dmi request taken, its response not yet taken
  logic dmi_busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (bus_req_valid && bus_req_ready) begin
      outstanding <= 1'b1;
    end else if (bus_resp_valid) begin
      outstanding <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dmi_busy <= 1'b0;
    end else if (dmi_req_valid && dmi_req_ready) begin
      dmi_busy <= 1'b1;
    end else if (dmi_resp_valid && dmi_resp_ready) begin
      dmi_busy <= 1'b0;
    end
  end

  resp_held: assert property (@(posedge clock) disable iff (reset)
    dmi_resp_valid && !dmi_resp_ready |=>
      dmi_resp_valid && $stable(dmi_resp_data) && $stable(dmi_resp_resp))
    else begin
      $error("dmi response changed while stalled");
      fail_count++;
    end

  no_req_while_resp: assert property (@(posedge clock) disable iff (reset)
    dmi_busy |-> !dmi_req_ready)
    else begin
      $error("dmi_req_ready high with a response pending");
      fail_count++;
    end

  single_outstanding: assert property (@(posedge clock) disable iff (reset)
    bus_req_valid && bus_req_ready |-> !outstanding)
    else begin
      $error("bus request issued before previous response");
      fail_count++;
    end

  resp_matches_req: assert property (@(posedge clock) disable iff (reset)
    bus_resp_valid |-> outstanding)
    else begin
      $error("bus response without a request");
      fail_count++;
    end

endmodule

bind debug_module soc_asserts asrt (
  .clock          (clock),
  .reset          (reset),
  .dmi_req_valid  (dmi_req_valid),
  .dmi_req_ready  (dmi_req_ready),
  .dmi_resp_valid (dmi_resp_valid),
  .dmi_resp_ready (dmi_resp_ready),
  .dmi_resp_data  (dmi_resp_data),
  .dmi_resp_resp  (dmi_resp_resp),
  .bus_req_valid  (bus.req_valid),
  .bus_req_ready  (bus.req_ready),
  .bus_resp_valid (bus.resp_valid)
);

/* testbench/tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top import soc_pkg::*; ();

  localparam int RAND_TXNS  = 400;
  localparam int TOTAL_TXNS = RAND_TXNS + 90;

  logic      clock;
  logic      reset;
  logic      dmi_req_valid;
  logic      dmi_req_ready;
  dmi_addr_t dmi_req_addr;
  data_t     dmi_req_data;
  dmi_op_t   dmi_req_op;
  logic      dmi_resp_valid;
  logic      dmi_resp_ready;
  data_t     dmi_resp_data;
  dmi_resp_t dmi_resp_resp;
  irq_t      ext_irq;
  led_t      led;
  irq_t      irq;

  integer seed;
  int     errors;
  int     checks;

  // reference model
  data_t      mem_m [64];
  data_t      led_m;
  irq_t       pend_m;
  irq_t       en_m;
  logic [1:0] dmc_m;

  soc_top #(.MEM_WORDS(64)) uut (
    .clock(clock), .reset(reset),
    .dmi_req_valid(dmi_req_valid), .dmi_req_ready(dmi_req_ready),
    .dmi_req_addr(dmi_req_addr), .dmi_req_data(dmi_req_data), .dmi_req_op(dmi_req_op),
    .dmi_resp_valid(dmi_resp_valid), .dmi_resp_ready(dmi_resp_ready),
    .dmi_resp_data(dmi_resp_data), .dmi_resp_resp(dmi_resp_resp),
    .ext_irq(ext_irq), .led(led), .irq(irq)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic int unsigned rand_u();
    rand_u = $unsigned($random(seed));
  endfunction

  function automatic data_t fill_word(input int a);
    fill_word = {9'h0, 7'(a), 9'h1a5, 7'(a)};
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // expected response, then the model takes the access
  task automatic model_access(input dmi_op_t op, input dmi_addr_t addr, input data_t wdata,
                              output data_t exp_data, output dmi_resp_t exp_resp);
    int a;
    a = int'(addr);
    exp_data = '0;
    exp_resp = dmi_resp_ok;
    if (!dmc_m[1]) begin
      pend_m = pend_m | ext_irq;
    end
    if (op == dmi_op_nop) begin
      exp_resp = dmi_resp_ok;
    end else if (a == 16) begin
      if (op == dmi_op_read) begin
        exp_data = data_t'(dmc_m);
      end else begin
        dmc_m = wdata[1:0];
        if (dmc_m[1]) begin
          led_m  = '0;
          pend_m = '0;
          en_m   = '0;
        end
      end
    end else if (dmc_m[1]) begin
      exp_resp = dmi_resp_failed;
    end else if (a >= 64) begin
      if (op == dmi_op_read) exp_data = mem_m[a - 64];
      else mem_m[a - 64] = wdata;
    end else if (a >= 32 && a < 36) begin
      if (op == dmi_op_read) begin
        case (a - 32)
          0: exp_data = led_m;
          1: exp_data = data_t'(pend_m);
          2: exp_data = data_t'(en_m);
          default: exp_data = data_t'(pend_m & en_m);
        endcase
      end else begin
        case (a - 32)
          0: led_m = wdata;
          1: pend_m = (pend_m & ~wdata[1:0]) | ext_irq;
          2: en_m = wdata[1:0];
          default: ;
        endcase
      end
    end else begin
      exp_resp = dmi_resp_failed;
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_txn(input dmi_op_t op, input dmi_addr_t addr, input data_t wdata);
    data_t     exp_data;
    dmi_resp_t exp_resp;
    data_t     got_data;
    dmi_resp_t got_resp;
    logic      done;
    model_access(op, addr, wdata, exp_data, exp_resp);
    // idle between transactions
    check_value("dmi_req_ready before request", data_t'(dmi_req_ready), 32'h1);
    dmi_req_valid = 1'b1;
    dmi_req_op    = op;
    dmi_req_addr  = addr;
    dmi_req_data  = wdata;
    while (!dmi_req_ready) @(negedge clock);
    @(negedge clock);
    dmi_req_valid = 1'b0;
    done = 1'b0;
    got_data = '0;
    got_resp = dmi_resp_ok;
    while (!done) begin
      dmi_resp_ready = ((rand_u() & 3) != 0);
      if (dmi_resp_valid && dmi_resp_ready) begin
        got_data = dmi_resp_data;
        got_resp = dmi_resp_resp;
        done = 1'b1;
      end
      @(negedge clock);
    end
    dmi_resp_ready = 1'b0;
    if (dmi_resp_valid) begin
      errors++;
      $display("Duplicate DMI response after address %h at %0t", addr, $time);
    end
    check_value($sformatf("resp code at %h", addr), data_t'(got_resp), data_t'(exp_resp));
    check_value($sformatf("resp data at %h", addr), got_data, exp_data);
    @(negedge clock);
    check_value("led output", data_t'(led), data_t'(led_m[15:0]));
    check_value("irq output", data_t'(irq), data_t'(pend_m & en_m));
  endtask

  task automatic random_txn();
    int unsigned kind;
    int unsigned u;
    dmi_addr_t   addr;
    dmi_op_t     op;
    data_t       wdata;
    if ((rand_u() & 3) == 0) ext_irq = irq_t'(rand_u() & 3);
    kind  = rand_u() % 20;
    u     = rand_u();
    wdata = data_t'(rand_u());
    op    = (rand_u() & 1) ? dmi_op_write : dmi_op_read;
    if (kind < 11) begin
      addr = dmi_addr_t'(64 + (u % 64));
    end else if (kind < 16) begin
      addr = dmi_addr_t'(32 + (u % 4));
    end else if (kind < 17) begin
      addr = dmi_addr_t'(16);
      // ndmreset now and then
      wdata = {30'b0, (u % 6) == 0, 1'b1};
    end else if (kind < 19) begin
      case (u % 3)
        0: addr = dmi_addr_t'(u % 16);
        1: addr = dmi_addr_t'(17 + (u % 15));
        default: addr = dmi_addr_t'(36 + (u % 28));
      endcase
    end else begin
      addr = dmi_addr_t'(u % 128);
      op   = dmi_op_nop;
    end
    run_txn(op, addr, wdata);
  endtask

  initial begin
    #(TOTAL_TXNS * 50 * 20);
    $display("Watchdog timeout, DUT stopped responding");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed = 46;
    errors = 0;
    checks = 0;
    reset = 1'b1;
    dmi_req_valid = 1'b0;
    dmi_req_addr = '0;
    dmi_req_data = '0;
    dmi_req_op = dmi_op_nop;
    dmi_resp_ready = 1'b0;
    ext_irq = '0;
    led_m = '0;
    pend_m = '0;
    en_m = '0;
    dmc_m = '0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    repeat (2) @(negedge clock);
    run_txn(dmi_op_write, DMCONTROL_ADDR, 32'h1);
    for (int a = 0; a < 64; a++) begin
      run_txn(dmi_op_write, dmi_addr_t'(64 + a), fill_word(64 + a));
    end
    for (int i = 0; i < RAND_TXNS; i++) begin
      random_txn();
    end
    // ndmreset sequence with known state
    run_txn(dmi_op_write, DMCONTROL_ADDR, 32'h1);
    run_txn(dmi_op_write, MMIO_BASE, 32'h0000beef);
    run_txn(dmi_op_write, dmi_addr_t'(34), 32'h3);
    ext_irq = 2'b10;
    run_txn(dmi_op_read, dmi_addr_t'(35), '0);
    ext_irq = 2'b00;
    run_txn(dmi_op_write, dmi_addr_t'(33), 32'h2);
    // uart pending set before the system reset
    ext_irq = 2'b01;
    run_txn(dmi_op_write, dmi_addr_t'(70), 32'hcafe0001);
    ext_irq = 2'b00;
    run_txn(dmi_op_write, DMCONTROL_ADDR, 32'h3);
    run_txn(dmi_op_read, dmi_addr_t'(70), '0);
    run_txn(dmi_op_write, DMCONTROL_ADDR, 32'h1);
    run_txn(dmi_op_read, MMIO_BASE, '0);
    run_txn(dmi_op_read, dmi_addr_t'(34), '0);
    run_txn(dmi_op_read, dmi_addr_t'(33), '0);
    run_txn(dmi_op_read, dmi_addr_t'(70), '0);
    run_txn(dmi_op_read, dmi_addr_t'(127), '0);
    errors += uut.dm.asrt.fail_count;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
src/soc_pkg.sv
src/sys_bus_if.sv
src/debug_module.sv
src/bus_router.sv
src/scratch_mem.sv
src/mmio_regs.sv
src/soc_top.sv
testbench/soc_asserts.sv
testbench/tb_soc_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_soc_top -o tb_soc_top_sim \
  && out=$(./obj_dir/tb_soc_top_sim) \
  && echo "$out" \
  && echo "$out" | grep -q "Simulation PASSED" \
  && exit 0 \
  || exit 1
